// File: all.f
+incdir+.
hififo_pkg.sv
hififo_wr_if.sv
pcie_rx.sv
pcie_tx.sv
hififo_controller.sv
hififo_timer.sv
hififo_tpc_fifo.sv
hififo_pcie.sv
tb_hififo_pcie.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_hififo_pcie
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) hififo_settings.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_hififo_pcie.sv
`timescale 1ns/100ps
`include "hififo_settings.svh"

module tb_hififo_pcie;
   import hififo_pkg::*;

   localparam int          TIMEOUT_CYCLES = 4000;
   localparam logic [31:0] SEED           = 32'h2305_4c6e;
   localparam logic [15:0] PCI_ID         = 16'h0a51;
   localparam logic [15:0] HOST_ID        = 16'h0100;

   logic        clock;
   logic        arst_n;
   logic [15:0] pci_id;
   logic        interrupt_out;
   logic        s_axis_tx_tready;
   logic [63:0] s_axis_tx_tdata;
   logic        s_axis_tx_tlast;
   logic        s_axis_tx_tvalid;
   logic        m_axis_rx_tvalid;
   logic        m_axis_rx_tlast;
   logic [63:0] m_axis_rx_tdata;
   logic [63:0] tpc0_data;
   logic        tpc0_write;
   logic        tpc0_ready;
   logic        pio_write_valid;
   logic [63:0] pio_write_data;
   logic [12:0] pio_address;

   string       test_name;
   int          cyc;
   logic [31:0] data_seed;
   logic [31:0] stall_seed;
   // 0 hold low, 1 always ready, 2 random stalls
   logic [1:0]  tready_mode;
   logic [63:0] beats[$];
   int          pkt_lens[$];
   int          pkt_ends[$];
   int          cur_len;
   int          irq_count;
   int          irq_cyc;
   logic [63:0] exp_words[$];
   logic [63:0] pkt[8];
   int          pkt_len;
   int          pkt_end;

   hififo_pcie DUT (.*);

   initial begin
      clock = 1'b0;
      forever #50 clock = ~clock;
   end

   always @(posedge clock) begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT_CYCLES) begin
         fail_stop($sformatf("timeout after %0d cycles, a test is stuck", TIMEOUT_CYCLES));
      end
   end

   always @(posedge clock) begin
      stall_seed <= lcg_next(stall_seed);
      case (tready_mode)
         2'd0:    s_axis_tx_tready <= 1'b0;
         2'd1:    s_axis_tx_tready <= 1'b1;
         default: s_axis_tx_tready <= stall_seed[28];
      endcase
   end

   // outgoing packets and interrupt pulses, sampled mid-cycle
   always @(negedge clock) begin
      if (arst_n && s_axis_tx_tvalid && s_axis_tx_tready) begin
         beats.push_back(s_axis_tx_tdata);
         cur_len = cur_len + 1;
         if (s_axis_tx_tlast) begin
            pkt_lens.push_back(cur_len);
            pkt_ends.push_back(cyc);
            cur_len = 0;
         end
      end
      if (arst_n && interrupt_out) begin
         irq_count = irq_count + 1;
         irq_cyc   = cyc;
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [63:0] rand64();
      logic [63:0] w;
      data_seed = lcg_next(data_seed);
      w[63:32]  = data_seed;
      data_seed = lcg_next(data_seed);
      w[31:0]   = data_seed;
      return w;
   endfunction

   function automatic logic [63:0] header(input tlp_kind_t kind, input logic [7:0] tag,
                                          input logic [12:0] addr);
      return {kind, tag, HOST_ID, 19'd0, addr};
   endfunction

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare_word(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
      if (act !== exp) begin
         fail_stop($sformatf("mismatch %s %s: expected %h actual %h",
                             test_name, what, exp, act));
      end
   endtask

   task automatic compare_kind(input string what, input tlp_kind_t exp, input tlp_kind_t act);
      if (act !== exp) begin
         fail_stop($sformatf("mismatch %s %s: expected %h actual %h",
                             test_name, what, exp, act));
      end
   endtask

   task automatic compare_tag(input string what, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         fail_stop($sformatf("mismatch %s %s: expected %h actual %h",
                             test_name, what, exp, act));
      end
   endtask

   task automatic send_beat(input logic [63:0] d, input logic last);
      @(posedge clock);
      m_axis_rx_tvalid <= 1'b1;
      m_axis_rx_tdata  <= d;
      m_axis_rx_tlast  <= last;
   endtask

   task automatic end_stream();
      @(posedge clock);
      m_axis_rx_tvalid <= 1'b0;
      m_axis_rx_tlast  <= 1'b0;
   endtask

   task automatic host_write(input logic [12:0] addr, input logic [63:0] d);
      send_beat(header(KIND_MWR, 8'h00, addr), 1'b0);
      send_beat(d, 1'b1);
      end_stream();
      // data beat taken at that last edge, echo shows for one cycle
      @(negedge clock);
      compare_word("pio_write_valid", 64'd1, {63'd0, pio_write_valid});
      compare_word("pio_address", {51'd0, addr}, {51'd0, pio_address});
      compare_word("pio_write_data", d, pio_write_data);
      @(negedge clock);
      compare_word("pio_write_valid pulse", 64'd0, {63'd0, pio_write_valid});
   endtask

   task automatic send_read(input logic [12:0] addr, input logic [7:0] tag);
      send_beat(header(KIND_MRD, tag, addr), 1'b1);
      end_stream();
   endtask

   task automatic pop_packet();
      while (pkt_lens.size() == 0) @(negedge clock);
      pkt_len = pkt_lens.pop_front();
      pkt_end = pkt_ends.pop_front();
      if (pkt_len > 8) begin
         fail_stop($sformatf("%s: outgoing packet of %0d beats is too long",
                             test_name, pkt_len));
      end
      for (int i = 0; i < pkt_len; i++) begin
         pkt[i] = beats.pop_front();
      end
   endtask

   task automatic expect_cpld(input logic [7:0] tag, input logic [63:0] d);
      pop_packet();
      compare_word("cpld length", 64'd2, 64'(pkt_len));
      compare_kind("cpld kind", KIND_CPLD, tlp_kind_t'(pkt[0][63:56]));
      compare_tag("cpld tag", tag, pkt[0][55:48]);
      compare_word("cpld pci_id", {48'd0, PCI_ID}, {48'd0, pkt[0][47:32]});
      compare_word("cpld address bits", 64'd0, {51'd0, pkt[0][12:0]});
      compare_word("cpld data", d, pkt[1]);
   endtask

   task automatic host_read(input logic [12:0] addr, input logic [7:0] tag,
                            input logic [63:0] d);
      send_read(addr, tag);
      expect_cpld(tag, d);
   endtask

   task automatic expect_mwr(input logic [63:0] addr);
      pop_packet();
      compare_word("mwr length", 64'(2 + `HIFIFO_BURST_WORDS), 64'(pkt_len));
      compare_kind("mwr kind", KIND_MWR, tlp_kind_t'(pkt[0][63:56]));
      compare_tag("mwr tag", 8'h00, pkt[0][55:48]);
      compare_word("mwr pci_id", {48'd0, PCI_ID}, {48'd0, pkt[0][47:32]});
      compare_word("mwr address bits", 64'd0, {51'd0, pkt[0][12:0]});
      compare_word("mwr host address", addr, pkt[1]);
      for (int i = 0; i < `HIFIFO_BURST_WORDS; i++) begin
         compare_word("mwr data", exp_words.pop_front(), pkt[2 + i]);
      end
   endtask

   task automatic push_word(input logic [63:0] w);
      @(posedge clock);
      tpc0_write <= 1'b1;
      tpc0_data  <= w;
      // accepted at the next edge once ready is high
      @(negedge clock);
      while (!tpc0_ready) @(negedge clock);
      exp_words.push_back(w);
   endtask

   task automatic push_random(input int n);
      for (int i = 0; i < n; i++) begin
         push_word(rand64());
      end
      @(posedge clock);
      tpc0_write <= 1'b0;
   endtask

   task automatic program_dma(input logic [63:0] base, input logic [63:0] words,
                              input logic [63:0] holdoff);
      host_write(`HIFIFO_REG_ADDR, base);
      host_write(`HIFIFO_REG_HOLDOFF, holdoff);
      host_write(`HIFIFO_REG_COUNT, words);
   endtask

   task automatic wait_irq(input int irq_base);
      while (irq_count == irq_base) @(negedge clock);
   endtask

   task automatic run_dma(input int words, input logic [7:0] tag);
      logic [63:0] base;
      int          irq_base;
      base     = rand64() & ~64'hfff;
      irq_base = irq_count;
      program_dma(base, 64'(words), 64'd3);
      push_random(words);
      for (int i = 0; i < words / `HIFIFO_BURST_WORDS; i++) begin
         expect_mwr(base + 64'(i * `HIFIFO_BURST_WORDS * 8));
      end
      wait_irq(irq_base);
      host_read(`HIFIFO_REG_SENT, tag, 64'(words));
   endtask

   task automatic test_pio_write_read();
      logic [63:0] addr_val;
      logic [63:0] hold_val;
      logic [7:0]  tag;
      test_name = "test_pio_write_read";
      @(negedge clock);
      compare_word("reset tvalid", 64'd0, {63'd0, s_axis_tx_tvalid});
      compare_word("reset interrupt", 64'd0, {63'd0, interrupt_out});
      compare_word("reset pio_write_valid", 64'd0, {63'd0, pio_write_valid});
      compare_word("reset tpc0_ready", 64'd1, {63'd0, tpc0_ready});
      addr_val = rand64();
      hold_val = rand64();
      host_write(`HIFIFO_REG_ADDR, addr_val);
      host_write(`HIFIFO_REG_HOLDOFF, hold_val);
      host_write(`HIFIFO_REG_SENT, rand64());
      tag = data_seed[7:0];
      host_read(`HIFIFO_REG_ADDR, tag, addr_val);
      host_read(`HIFIFO_REG_COUNT, tag + 8'd1, 64'd0);
      host_read(`HIFIFO_REG_HOLDOFF, tag + 8'd2, {32'd0, hold_val[31:0]});
      host_read(`HIFIFO_REG_SENT, tag + 8'd3, 64'd0);
   endtask

   task automatic test_dma_basic();
      test_name = "test_dma_basic";
      run_dma(8, 8'h21);
   endtask

   task automatic test_backpressure();
      test_name = "test_backpressure";
      @(posedge clock);
      tready_mode <= 2'd2;
      run_dma(16, 8'h33);
      @(posedge clock);
      tready_mode <= 2'd1;
   endtask

   task automatic test_fifo_full();
      logic [63:0] base;
      logic [63:0] w;
      int          accepted;
      int          irq_base;
      test_name = "test_fifo_full";
      base      = rand64() & ~64'hfff;
      irq_base  = irq_count;
      accepted  = 0;
      host_write(`HIFIFO_REG_ADDR, base);
      host_write(`HIFIFO_REG_HOLDOFF, 64'd3);
      while (accepted <= `HIFIFO_TPC_DEPTH) begin
         w = rand64();
         @(posedge clock);
         tpc0_write <= 1'b1;
         tpc0_data  <= w;
         @(negedge clock);
         if (!tpc0_ready) begin
            break;
         end
         exp_words.push_back(w);
         accepted = accepted + 1;
      end
      @(posedge clock);
      tpc0_write <= 1'b0;
      compare_word("accepted words", 64'(`HIFIFO_TPC_DEPTH), 64'(accepted));
      host_write(`HIFIFO_REG_COUNT, 64'(`HIFIFO_TPC_DEPTH));
      for (int i = 0; i < `HIFIFO_TPC_DEPTH / `HIFIFO_BURST_WORDS; i++) begin
         expect_mwr(base + 64'(i * `HIFIFO_BURST_WORDS * 8));
      end
      wait_irq(irq_base);
   endtask

   task automatic test_interrupt();
      logic [63:0] base;
      int          irq_base;
      int          last_end;
      test_name = "test_interrupt";
      base      = rand64() & ~64'hfff;
      irq_base  = irq_count;
      program_dma(base, 64'd8, 64'd20);
      push_random(8);
      expect_mwr(base);
      expect_mwr(base + 64'd32);
      last_end = pkt_end;
      // timer loads one edge after the last beat, fires holdoff + 1 later
      while (cyc < last_end + 40) @(negedge clock);
      compare_word("interrupt pulses", 64'd1, 64'(irq_count - irq_base));
      compare_word("interrupt delay", 64'd23, 64'(irq_cyc - last_end));
   endtask

   task automatic test_cpl_priority();
      logic [63:0] base;
      int          irq_base;
      test_name = "test_cpl_priority";
      base      = rand64() & ~64'hfff;
      irq_base  = irq_count;
      @(posedge clock);
      tready_mode <= 2'd0;
      program_dma(base, 64'd8, 64'd3);
      push_random(8);
      // first header is now stuck on the link
      while (!s_axis_tx_tvalid) @(negedge clock);
      send_read(`HIFIFO_REG_ADDR, 8'h5c);
      repeat (2) @(posedge clock);
      tready_mode <= 2'd1;
      expect_mwr(base);
      expect_cpld(8'h5c, base);
      expect_mwr(base + 64'd32);
      wait_irq(irq_base);
   endtask

   initial begin
      arst_n           = 1'b0;
      pci_id           = PCI_ID;
      s_axis_tx_tready = 1'b1;
      m_axis_rx_tvalid = 1'b0;
      m_axis_rx_tlast  = 1'b0;
      m_axis_rx_tdata  = 64'd0;
      tpc0_data        = 64'd0;
      tpc0_write       = 1'b0;
      tready_mode      = 2'd1;
      data_seed        = SEED;
      stall_seed       = SEED;
      cyc              = 0;
      cur_len          = 0;
      irq_count        = 0;
      irq_cyc          = 0;
      test_name        = "reset";
      repeat (8) @(posedge clock);
      arst_n <= 1'b1;
      test_pio_write_read();
      test_dma_basic();
      test_backpressure();
      test_fifo_full();
      test_interrupt();
      test_cpl_priority();
      repeat (4) @(posedge clock);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// File: hififo_pcie.sv
`timescale 1ns/100ps
`include "hififo_settings.svh"

module hififo_pcie (
   input  logic        clock,
   input  logic        arst_n,
   input  logic [15:0] pci_id,
   output logic        interrupt_out,
   input  logic        s_axis_tx_tready,
   output logic [63:0] s_axis_tx_tdata,
   output logic        s_axis_tx_tlast,
   output logic        s_axis_tx_tvalid,
   input  logic        m_axis_rx_tvalid,
   input  logic        m_axis_rx_tlast,
   input  logic [63:0] m_axis_rx_tdata,
   input  logic [63:0] tpc0_data,
   input  logic        tpc0_write,
   output logic        tpc0_ready,
   output logic        pio_write_valid,
   output logic [63:0] pio_write_data,
   output logic [12:0] pio_address
);
   import hififo_pkg::*;

   pio_req_t rx_read_req;
   logic     rx_read_valid;
   cpl_t     tx_cpl;
   logic     tx_cpl_valid;
   logic     tx_cpl_done;
   logic     timer_load;
   logic     [31:0] holdoff;
   logic     [$clog2(`HIFIFO_TPC_DEPTH):0] fifo_level;

   hififo_wr_if wr_if ();

   // PIO writes go out on the pio ports and into the registers
   pcie_rx rx (
      .clock       (clock),
      .arst_n      (arst_n),
      .tvalid      (m_axis_rx_tvalid),
      .tlast       (m_axis_rx_tlast),
      .tdata       (m_axis_rx_tdata),
      .write_valid (pio_write_valid),
      .address     (pio_address),
      .data        (pio_write_data),
      .read_valid  (rx_read_valid),
      .read_req    (rx_read_req)
   );

   hififo_controller hififo_controller (
      .clock         (clock),
      .arst_n        (arst_n),
      .write_valid   (pio_write_valid),
      .address       (pio_address),
      .data          (pio_write_data),
      .read_valid    (rx_read_valid),
      .read_req      (rx_read_req),
      .cpl_valid     (tx_cpl_valid),
      .cpl           (tx_cpl),
      .cpl_done      (tx_cpl_done),
      .fifo_level    (fifo_level),
      .timer_load    (timer_load),
      .holdoff       (holdoff),
      .timer_expired (interrupt_out),
      .wr            (wr_if.ctrl)
   );

   hififo_timer timer (
      .clock   (clock),
      .arst_n  (arst_n),
      .load    (timer_load),
      .holdoff (holdoff),
      .expired (interrupt_out)
   );

   hififo_tpc_fifo tpc0_fifo (
      .clock      (clock),
      .arst_n     (arst_n),
      .fifo_data  (tpc0_data),
      .fifo_write (tpc0_write),
      .fifo_ready (tpc0_ready),
      .level      (fifo_level),
      .rd         (wr_if.fifo)
   );

   pcie_tx tx (
      .clock     (clock),
      .arst_n    (arst_n),
      .pcie_id   (pci_id),
      .cpl_valid (tx_cpl_valid),
      .cpl       (tx_cpl),
      .cpl_done  (tx_cpl_done),
      .tx_tready (s_axis_tx_tready),
      .tx_tdata  (s_axis_tx_tdata),
      .tx_tlast  (s_axis_tx_tlast),
      .tx_tvalid (s_axis_tx_tvalid),
      .wr        (wr_if.tx)
   );

endmodule

// File: hififo_tpc_fifo.sv
`timescale 1ns/100ps
`include "hififo_settings.svh"

module hififo_tpc_fifo (
   input  logic                                 clock,
   input  logic                                 arst_n,
   input  logic [63:0]                          fifo_data,
   input  logic                                 fifo_write,
   output logic                                 fifo_ready,
   output logic [$clog2(`HIFIFO_TPC_DEPTH):0]   level,
   hififo_wr_if.fifo                            rd
);

   localparam int DEPTH = `HIFIFO_TPC_DEPTH;
   localparam int AW    = $clog2(DEPTH);

   logic [63:0]   mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic          push;
   logic          pop;

   assign fifo_ready = (level != DEPTH);
   assign push       = fifo_write && fifo_ready;
   assign pop        = rd.rd_en;
   // head falls through
   assign rd.rd_data = mem[rd_ptr];

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (push) begin
         mem[wr_ptr] <= fifo_data;
      end
   end

   // pointer distance agrees with the level count
   a_level_match: assert property (@(posedge clock) disable iff (!arst_n)
      level[AW-1:0] == wr_ptr - rd_ptr);

   // tx only pops words the controller has already seen
   a_no_underflow: assert property (@(posedge clock) disable iff (!arst_n)
      rd.rd_en |-> level != 0);

endmodule

// File: hififo_timer.sv
`timescale 1ns/100ps

module hififo_timer (
   input  logic        clock,
   input  logic        arst_n,
   input  logic        load,
   input  logic [31:0] holdoff,
   output logic        expired
);

   logic [31:0] count;
   logic        active;

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         count   <= 32'd0;
         active  <= 1'b0;
         expired <= 1'b0;
      end else begin
         expired <= 1'b0;
         if (load) begin
            count  <= holdoff;
            active <= 1'b1;
         end else if (active) begin
            // one pulse, then idle until the next load
            if (count == 32'd0) begin
               expired <= 1'b1;
               active  <= 1'b0;
            end else begin
               count <= count - 32'd1;
            end
         end
      end
   end

endmodule

// File: hififo_controller.sv
`timescale 1ns/100ps
`include "hififo_settings.svh"

module hififo_controller (
   input  logic                                 clock,
   input  logic                                 arst_n,
   input  logic                                 write_valid,
   input  logic [12:0]                          address,
   input  logic [63:0]                          data,
   input  logic                                 read_valid,
   input  hififo_pkg::pio_req_t                 read_req,
   output logic                                 cpl_valid,
   output hififo_pkg::cpl_t                     cpl,
   input  logic                                 cpl_done,
   input  logic [$clog2(`HIFIFO_TPC_DEPTH):0]   fifo_level,
   output logic                                 timer_load,
   output logic [31:0]                          holdoff,
   input  logic                                 timer_expired,
   hififo_wr_if.ctrl                            wr
);
   import hififo_pkg::*;

   localparam logic [12:0] REG_ADDR    = `HIFIFO_REG_ADDR;
   localparam logic [12:0] REG_COUNT   = `HIFIFO_REG_COUNT;
   localparam logic [12:0] REG_HOLDOFF = `HIFIFO_REG_HOLDOFF;
   localparam logic [12:0] REG_SENT    = `HIFIFO_REG_SENT;
   localparam logic [31:0] BURST_LEN   = `HIFIFO_BURST_WORDS;
   localparam logic [63:0] BURST_BYTES = `HIFIFO_BURST_WORDS * 8;

   ctrl_state_t state;
   logic [63:0] base_addr;
   logic [63:0] burst_off;
   logic [31:0] count;
   logic [31:0] pop_left;
   logic [31:0] sent;
   logic [31:0] count_in;
   logic [63:0] read_data;
   logic        burst_ok;

   // count rounded up to whole bursts
   assign count_in = (data[31:0] + BURST_LEN - 32'd1) & ~(BURST_LEN - 32'd1);

   // enough unclaimed words: level minus words granted but not yet popped
   assign burst_ok = (count != 32'd0) && (32'(fifo_level) + count >= pop_left + BURST_LEN);

   assign wr.wr_addr = base_addr + burst_off;

   always_comb begin
      case (read_req.addr[12:3])
         REG_ADDR[12:3]:    read_data = base_addr;
         REG_COUNT[12:3]:   read_data = {32'd0, count};
         REG_HOLDOFF[12:3]: read_data = {32'd0, holdoff};
         REG_SENT[12:3]:    read_data = {32'd0, sent};
         default:           read_data = 64'd0;
      endcase
   end

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         state       <= IDLE;
         base_addr   <= 64'd0;
         burst_off   <= 64'd0;
         count       <= 32'd0;
         pop_left    <= 32'd0;
         sent        <= 32'd0;
         holdoff     <= 32'd0;
         wr.wr_valid <= 1'b0;
         timer_load  <= 1'b0;
         cpl_valid   <= 1'b0;
      end else begin
         timer_load <= 1'b0;
         if (write_valid && address[12:3] == REG_ADDR[12:3]) begin
            base_addr <= data;
         end
         if (write_valid && address[12:3] == REG_HOLDOFF[12:3]) begin
            holdoff <= data[31:0];
         end
         if (wr.rd_en) begin
            sent     <= sent + 32'd1;
            pop_left <= pop_left - 32'd1;
         end

         case (state)
            IDLE: begin
               if (write_valid && address[12:3] == REG_COUNT[12:3] && data[31:0] != 32'd0) begin
                  count     <= count_in;
                  pop_left  <= count_in;
                  sent      <= 32'd0;
                  burst_off <= 64'd0;
                  state     <= ARMED;
               end
            end
            ARMED: begin
               // final word gone, start holdoff
               if (wr.rd_en && pop_left == 32'd1) begin
                  timer_load <= 1'b1;
                  state      <= HOLDOFF;
               end else if (burst_ok) begin
                  wr.wr_valid <= 1'b1;
                  state       <= BURST;
               end
            end
            BURST: begin
               if (wr.wr_ready) begin
                  wr.wr_valid <= 1'b0;
                  count       <= count - BURST_LEN;
                  burst_off   <= burst_off + BURST_BYTES;
                  state       <= ARMED;
               end
            end
            HOLDOFF: begin
               if (timer_expired) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase

         if (read_valid) begin
            cpl_valid <= 1'b1;
         end else if (cpl_done) begin
            cpl_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (read_valid) begin
         cpl <= '{tag: read_req.tag, id: read_req.id, data: read_data};
      end
   end

   // host keeps a single read outstanding
   a_one_read: assert property (@(posedge clock) disable iff (!arst_n)
      read_valid |-> !cpl_valid);

endmodule

// File: pcie_tx.sv
`timescale 1ns/100ps
`include "hififo_settings.svh"

module pcie_tx (
   input  logic             clock,
   input  logic             arst_n,
   input  logic [15:0]      pcie_id,
   input  logic             cpl_valid,
   input  hififo_pkg::cpl_t cpl,
   output logic             cpl_done,
   input  logic             tx_tready,
   output logic [63:0]      tx_tdata,
   output logic             tx_tlast,
   output logic             tx_tvalid,
   hififo_wr_if.tx          wr
);
   import hififo_pkg::*;

   // header, address, then data words
   localparam int MWR_BEATS = 2 + `HIFIFO_BURST_WORDS;

   logic [2:0]  beat;
   logic        is_cpl;
   logic [63:0] beat_q;
   logic [63:0] next_q;
   logic        adv;
   logic        boundary;
   logic        start_cpl;
   logic        start_wr;
   logic        data_phase;

   assign adv       = !tx_tvalid || tx_tready;
   assign boundary  = !tx_tvalid || tx_tlast;
   // completion wins at a packet boundary
   assign start_cpl = adv && boundary && cpl_valid;
   assign wr.wr_ready = adv && boundary && !cpl_valid;
   assign start_wr  = wr.wr_ready && wr.wr_valid;
   assign cpl_done  = start_cpl;

   // data beats come straight off the FIFO head
   assign data_phase = !is_cpl && beat > 3'd1;
   assign tx_tdata   = data_phase ? wr.rd_data : beat_q;
   assign wr.rd_en   = tx_tvalid && tx_tready && data_phase;

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         tx_tvalid <= 1'b0;
         tx_tlast  <= 1'b0;
         beat      <= 3'd0;
         is_cpl    <= 1'b0;
      end else if (adv) begin
         if (boundary) begin
            tx_tvalid <= start_cpl || start_wr;
            tx_tlast  <= 1'b0;
            beat      <= 3'd0;
            is_cpl    <= start_cpl;
         end else begin
            beat     <= beat + 3'd1;
            tx_tlast <= is_cpl || (beat == MWR_BEATS - 2);
         end
      end
   end

   always_ff @(posedge clock) begin
      if (start_cpl) begin
         beat_q <= {KIND_CPLD, cpl.tag, pcie_id, cpl.id, 16'h0000};
         next_q <= cpl.data;
      end else if (start_wr) begin
         beat_q <= {KIND_MWR, 8'h00, pcie_id, 32'h0000_0000};
         next_q <= wr.wr_addr;
      end else if (adv && !boundary && beat == 3'd0) begin
         beat_q <= next_q;
      end
   end

   // the FIFO head must hold while the core stalls us
   a_tx_stable: assert property (@(posedge clock) disable iff (!arst_n)
      tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata) && $stable(tx_tlast));

endmodule

// File: pcie_rx.sv
`timescale 1ns/100ps

module pcie_rx (
   input  logic                 clock,
   input  logic                 arst_n,
   input  logic                 tvalid,
   input  logic                 tlast,
   input  logic [63:0]          tdata,
   output logic                 write_valid,
   output logic [12:0]          address,
   output logic [63:0]          data,
   output logic                 read_valid,
   output hififo_pkg::pio_req_t read_req
);
   import hififo_pkg::*;

   logic        first_beat;
   logic [7:0]  hdr_kind;
   logic [12:0] hdr_addr;

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         first_beat  <= 1'b1;
         write_valid <= 1'b0;
         read_valid  <= 1'b0;
      end else begin
         write_valid <= 1'b0;
         read_valid  <= 1'b0;
         if (tvalid) begin
            first_beat <= tlast;
            if (first_beat) begin
               // a host read is a lone header beat
               if (tdata[63:56] == KIND_MRD && tlast) begin
                  read_valid <= 1'b1;
               end
            end else if (hdr_kind == KIND_MWR) begin
               write_valid <= 1'b1;
            end
         end
      end
   end

   // header fields and payload
   always_ff @(posedge clock) begin
      if (tvalid && first_beat) begin
         hdr_kind <= tdata[63:56];
         hdr_addr <= tdata[12:0];
         read_req <= '{tag: tdata[55:48], id: tdata[47:32], addr: tdata[12:0]};
      end
      if (tvalid && !first_beat) begin
         address <= hdr_addr;
         data    <= tdata;
      end
   end

endmodule

// File: hififo_wr_if.sv
`timescale 1ns/100ps

interface hififo_wr_if;

   // burst request, controller to tx
   logic        wr_valid;
   logic [63:0] wr_addr;
   logic        wr_ready;

   // FIFO head and pop
   logic        rd_en;
   logic [63:0] rd_data;

   // controller also watches pops to count words sent
   modport ctrl (output wr_valid, output wr_addr, input wr_ready, input rd_en);

   modport tx (input wr_valid, input wr_addr, output wr_ready, output rd_en,
               input rd_data);

   modport fifo (input rd_en, output rd_data);

endinterface

// File: hififo_pkg.sv
package hififo_pkg;

   // packet kind, beat 0 bits 63..56
   typedef enum logic [7:0] {
      KIND_MRD  = 8'h00,
      KIND_MWR  = 8'h40,
      KIND_CPLD = 8'h4A
   } tlp_kind_t;

   // host read request waiting for an answer
   typedef struct packed {
      logic [7:0]  tag;
      logic [15:0] id;
      logic [12:0] addr;
   } pio_req_t;

   // completion handed to the transmitter
   typedef struct packed {
      logic [7:0]  tag;
      logic [15:0] id;
      logic [63:0] data;
   } cpl_t;

   typedef enum logic [1:0] {
      IDLE,
      ARMED,
      BURST,
      HOLDOFF
   } ctrl_state_t;

endpackage

// File: hififo_settings.svh
`ifndef HIFIFO_SETTINGS_SVH
`define HIFIFO_SETTINGS_SVH

// data words per outgoing memory-write packet
`define HIFIFO_BURST_WORDS 4

// to-host FIFO depth in 64-bit words
`define HIFIFO_TPC_DEPTH 16

// PIO byte offsets, register picked by address bits 12..3
`define HIFIFO_REG_ADDR    13'h000
`define HIFIFO_REG_COUNT   13'h008
`define HIFIFO_REG_HOLDOFF 13'h010
`define HIFIFO_REG_SENT    13'h018

`endif
